// File: Makefile
# Verilator build for the ooo core testbench

VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
rtl/ooo_pkg.sv
rtl/rs_scheduler.sv
rtl/reg_status.sv
rtl/res_station.sv
rtl/alu_unit.sv
rtl/rob.sv
rtl/ooo_core.sv
testbench/ooo_checker.sv
testbench/tb_ooo_core.sv

// File: rtl/alu_unit.sv
// ################################################
// execute stage, single cycle alu
// result registered onto the common data bus
// ################################################

`timescale 1ns/100ps
`default_nettype none

module alu_unit
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     disp_valid,
    input  alu_op_e  disp_op,
    input  rob_tag_t disp_tag,
    input  word_t    disp_a,
    input  word_t    disp_b,
    output logic     cdb_valid,
    output rob_tag_t cdb_tag,
    output word_t    cdb_value
);

    word_t result;

    always_comb begin
        case (disp_op)
            op_sub:  result = disp_a - disp_b;
            op_and:  result = disp_a & disp_b;
            op_xor:  result = disp_a ^ disp_b;
            op_mul:  result = disp_a * disp_b; // low 32 bits
            default: result = disp_a + disp_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= disp_valid;
        cdb_tag   <= disp_tag;
        cdb_value <= result;
    end

endmodule

`default_nettype wire

// File: rtl/ooo_core.sv
// ################################################
// ooo core top: wishbone slave and stage wiring
// issue, station, execute, commit
// ################################################

`timescale 1ns/100ps
`default_nettype none

module ooo_core
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  reg_idx_t wb_adr,
    input  word_t    wb_dat_w,
    output word_t    wb_dat_r,
    output logic     wb_ack,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output word_t    commit_value
);

    logic issue_req, rd_req, stall;

    reg_idx_t rs1, rs2, rd;
    logic     rs_load, rob_alloc, tag_write;
    rs_idx_t  rs_slot;
    alu_op_e  op;
    word_t    v_j, v_k;
    rob_tag_t q_j, q_k;

    rob_tag_t reg_tag_j, reg_tag_k;
    word_t    reg_val_j, reg_val_k, rd_data;

    rob_tag_t rob_tag_free, commit_tag;
    logic     rob_full, rob_ready_j, rob_ready_k;
    word_t    rob_val_j, rob_val_k;

    logic [rs_depth-1:0] rs_busy;
    logic     disp_valid;
    alu_op_e  disp_op;
    rob_tag_t disp_tag;
    word_t    disp_a, disp_b;

    logic     cdb_valid;
    rob_tag_t cdb_tag;
    word_t    cdb_value;

    assign issue_req = wb_cyc && wb_stb && wb_we && !wb_ack;
    assign rd_req    = wb_cyc && wb_stb && !wb_we && !wb_ack;

    // writes wait out stall, reads never do
    always_ff @(posedge clk) begin
        if (reset)
            wb_ack <= 1'b0;
        else
            wb_ack <= (issue_req && !stall) || rd_req;
        if (rd_req)
            wb_dat_r <= rd_data;
    end

    rs_scheduler sched0 (
        .instr(wb_dat_w), .issue_req(issue_req), .rs_busy(rs_busy), .rob_full(rob_full),
        .rob_tag_free(rob_tag_free), .reg_tag_j(reg_tag_j), .reg_tag_k(reg_tag_k),
        .reg_val_j(reg_val_j), .reg_val_k(reg_val_k), .rob_ready_j(rob_ready_j),
        .rob_ready_k(rob_ready_k), .rob_val_j(rob_val_j), .rob_val_k(rob_val_k),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .rs1(rs1), .rs2(rs2), .rd(rd), .rs_load(rs_load), .rs_slot(rs_slot), .op(op),
        .v_j(v_j), .q_j(q_j), .v_k(v_k), .q_k(q_k), .rob_alloc(rob_alloc),
        .tag_write(tag_write), .stall(stall)
    );

    reg_status regs0 (
        .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd_issue(rd),
        .tag_issue(rob_tag_free), .tag_write(tag_write), .commit_valid(commit_valid),
        .commit_rd(commit_rd), .commit_tag(commit_tag), .commit_value(commit_value),
        .rd_addr(wb_adr), .val_j(reg_val_j), .val_k(reg_val_k), .tag_j(reg_tag_j),
        .tag_k(reg_tag_k), .rd_data(rd_data)
    );

    res_station rs0 (
        .clk(clk), .reset(reset), .load(rs_load), .slot(rs_slot), .op(op),
        .v_j(v_j), .q_j(q_j), .v_k(v_k), .q_k(q_k), .tag(rob_tag_free),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .busy(rs_busy), .disp_valid(disp_valid), .disp_op(disp_op),
        .disp_tag(disp_tag), .disp_a(disp_a), .disp_b(disp_b)
    );

    alu_unit alu0 (
        .clk(clk), .reset(reset), .disp_valid(disp_valid), .disp_op(disp_op),
        .disp_tag(disp_tag), .disp_a(disp_a), .disp_b(disp_b),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

    rob rob0 (
        .clk(clk), .reset(reset), .alloc(rob_alloc), .alloc_rd(rd),
        .lookup_j(reg_tag_j), .lookup_k(reg_tag_k), .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag), .cdb_value(cdb_value), .free_tag(rob_tag_free),
        .full(rob_full), .ready_j(rob_ready_j), .ready_k(rob_ready_k),
        .val_j(rob_val_j), .val_k(rob_val_k), .commit_valid(commit_valid),
        .commit_rd(commit_rd), .commit_tag(commit_tag), .commit_value(commit_value)
    );

endmodule

`default_nettype wire

// File: rtl/ooo_pkg.sv
// ################################################
// ooo core shared definitions
// sizes, tag and data types, alu ops, opcodes
// ################################################

`default_nettype none

package ooo_pkg;

    // structure sizes
    localparam int rs_depth  = 4;
    localparam int rob_depth = 7;

    // rv32 major opcodes handled by the issue stage
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    typedef logic [31:0] word_t;     // data or instruction word
    typedef logic [4:0]  reg_idx_t;  // architectural register number

    // zero means value present, no producer
    typedef logic [2:0]  rob_tag_t;

    typedef logic [1:0]  rs_idx_t;   // station slot

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_xor = 3'd3,
        op_mul = 3'd4
    } alu_op_e;

endpackage

`default_nettype wire

// File: rtl/reg_status.sv
// ################################################
// architectural register file with producer tags
// renamed at issue, written back at commit
// ################################################

`timescale 1ns/100ps
`default_nettype none

module reg_status
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd_issue,
    input  rob_tag_t tag_issue,
    input  logic     tag_write,
    input  logic     commit_valid,
    input  reg_idx_t commit_rd,
    input  rob_tag_t commit_tag,
    input  word_t    commit_value,
    input  reg_idx_t rd_addr,
    output word_t    val_j,
    output word_t    val_k,
    output rob_tag_t tag_j,
    output rob_tag_t tag_k,
    output word_t    rd_data
);

    word_t    regs [32];
    rob_tag_t tags [32];

    logic issue_hit;
    logic commit_hit;

    // x0 is never written so it reads zero
    assign issue_hit  = tag_write && rd_issue != '0;
    assign commit_hit = commit_valid && commit_rd != '0;

    assign val_j   = regs[rs1];
    assign val_k   = regs[rs2];
    assign tag_j   = tags[rs1];
    assign tag_k   = tags[rs2];
    assign rd_data = regs[rd_addr]; // host read port

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (commit_hit) begin
                regs[commit_rd] <= commit_value;
                // only clear if no younger producer took over
                if (tags[commit_rd] == commit_tag)
                    tags[commit_rd] <= '0;
            end
            if (issue_hit)
                tags[rd_issue] <= tag_issue; // issue beats commit
        end
    end

endmodule

`default_nettype wire

// File: rtl/res_station.sv
// ################################################
// reservation station, four entries
// cdb wakeup, dispatches oldest ready entry
// ################################################

`timescale 1ns/100ps
`default_nettype none

module res_station
    import ooo_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                load,
    input  rs_idx_t             slot,
    input  alu_op_e             op,
    input  word_t               v_j,
    input  rob_tag_t            q_j,
    input  word_t               v_k,
    input  rob_tag_t            q_k,
    input  rob_tag_t            tag,
    input  logic                cdb_valid,
    input  rob_tag_t            cdb_tag,
    input  word_t               cdb_value,
    output logic [rs_depth-1:0] busy,
    output logic                disp_valid,
    output alu_op_e             disp_op,
    output rob_tag_t            disp_tag,
    output word_t               disp_a,
    output word_t               disp_b
);

    alu_op_e  e_op  [rs_depth];
    word_t    e_vj  [rs_depth];
    word_t    e_vk  [rs_depth];
    rob_tag_t e_qj  [rs_depth];
    rob_tag_t e_qk  [rs_depth];
    rob_tag_t e_tag [rs_depth];
    rs_idx_t  e_age [rs_depth]; // number of older entries still held

    rs_idx_t    disp_slot;
    rs_idx_t    new_age;
    logic [2:0] n_busy;

    // oldest entry with both operands present
    always_comb begin
        rs_idx_t best_age;
        disp_valid = 1'b0;
        disp_slot  = '0;
        best_age   = '0;
        for (int i = 0; i < rs_depth; i++) begin
            if (busy[i] && e_qj[i] == '0 && e_qk[i] == '0 &&
                (!disp_valid || e_age[i] < best_age)) begin
                disp_valid = 1'b1;
                disp_slot  = rs_idx_t'(i);
                best_age   = e_age[i];
            end
        end
    end

    assign disp_op  = e_op[disp_slot];
    assign disp_tag = e_tag[disp_slot];
    assign disp_a   = e_vj[disp_slot];
    assign disp_b   = e_vk[disp_slot];

    always_comb begin
        n_busy = '0;
        for (int i = 0; i < rs_depth; i++)
            n_busy = n_busy + 3'(busy[i]);
    end

    // entry leaving this cycle no longer counts as older
    assign new_age = rs_idx_t'(n_busy - 3'(disp_valid));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
            for (int i = 0; i < rs_depth; i++)
                e_age[i] <= '0;
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                // wakeup
                if (busy[i] && e_qj[i] != '0 && cdb_valid && cdb_tag == e_qj[i]) begin
                    e_vj[i] <= cdb_value;
                    e_qj[i] <= '0;
                end
                if (busy[i] && e_qk[i] != '0 && cdb_valid && cdb_tag == e_qk[i]) begin
                    e_vk[i] <= cdb_value;
                    e_qk[i] <= '0;
                end
                if (disp_valid && e_age[i] > e_age[disp_slot])
                    e_age[i] <= e_age[i] - 2'd1;
            end
            if (disp_valid)
                busy[disp_slot] <= 1'b0;
            if (load) begin
                busy[slot]  <= 1'b1;
                e_op[slot]  <= op;
                e_vj[slot]  <= v_j;
                e_qj[slot]  <= q_j;
                e_vk[slot]  <= v_k;
                e_qk[slot]  <= q_k;
                e_tag[slot] <= tag;
                e_age[slot] <= new_age;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rob.sv
// ################################################
// reorder buffer, seven entries, tag = slot + 1
// captures cdb results, commits in order
// ################################################

`timescale 1ns/100ps
`default_nettype none

module rob
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     alloc,
    input  reg_idx_t alloc_rd,
    input  rob_tag_t lookup_j,
    input  rob_tag_t lookup_k,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    output rob_tag_t free_tag,
    output logic     full,
    output logic     ready_j,
    output logic     ready_k,
    output word_t    val_j,
    output word_t    val_k,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output rob_tag_t commit_tag,
    output word_t    commit_value
);

    word_t    e_val [rob_depth];
    reg_idx_t e_rd  [rob_depth];
    logic [rob_depth-1:0] e_rdy; // held after retire until the slot is reused

    logic [2:0] head;
    logic [2:0] tail;
    logic [2:0] count;
    logic       retire;

    function automatic logic [2:0] next_slot(input logic [2:0] p);
        return (p == 3'(rob_depth - 1)) ? 3'd0 : p + 3'd1;
    endfunction

    assign free_tag = rob_tag_t'(tail + 3'd1);
    assign full     = count == 3'(rob_depth);
    assign retire   = count != '0 && e_rdy[head];

    // operand lookup by tag
    always_comb begin
        ready_j = 1'b0;
        ready_k = 1'b0;
        val_j   = '0;
        val_k   = '0;
        for (int i = 0; i < rob_depth; i++) begin
            if (lookup_j == rob_tag_t'(i + 1)) begin
                ready_j = e_rdy[i];
                val_j   = e_val[i];
            end
            if (lookup_k == rob_tag_t'(i + 1)) begin
                ready_k = e_rdy[i];
                val_k   = e_val[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            e_rdy        <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            if (alloc) begin
                e_rd[tail]  <= alloc_rd;
                e_rdy[tail] <= 1'b0;
                tail        <= next_slot(tail);
            end
            for (int i = 0; i < rob_depth; i++) begin
                if (cdb_valid && cdb_tag == rob_tag_t'(i + 1)) begin
                    e_val[i] <= cdb_value;
                    e_rdy[i] <= 1'b1;
                end
            end
            if (retire)
                head <= next_slot(head);
            count <= count + 3'(alloc) - 3'(retire);
        end
        commit_rd    <= e_rd[head];
        commit_value <= e_val[head];
        commit_tag   <= rob_tag_t'(head + 3'd1);
    end

endmodule

`default_nettype wire

// File: rtl/rs_scheduler.sv
// ################################################
// issue stage: decode, rename, operand forwarding
// picks a free station slot and raises stall
// ################################################

`timescale 1ns/100ps
`default_nettype none

module rs_scheduler
    import ooo_pkg::*;
(
    input  word_t               instr,
    input  logic                issue_req,
    input  logic [rs_depth-1:0] rs_busy,
    input  logic                rob_full,
    input  rob_tag_t            rob_tag_free,
    input  rob_tag_t            reg_tag_j,
    input  rob_tag_t            reg_tag_k,
    input  word_t               reg_val_j,
    input  word_t               reg_val_k,
    input  logic                rob_ready_j,
    input  logic                rob_ready_k,
    input  word_t               rob_val_j,
    input  word_t               rob_val_k,
    input  logic                cdb_valid,
    input  rob_tag_t            cdb_tag,
    input  word_t               cdb_value,
    output reg_idx_t            rs1,
    output reg_idx_t            rs2,
    output reg_idx_t            rd,
    output logic                rs_load,
    output rs_idx_t             rs_slot,
    output alu_op_e             op,
    output word_t               v_j,
    output rob_tag_t            q_j,
    output word_t               v_k,
    output rob_tag_t            q_k,
    output logic                rob_alloc,
    output logic                tag_write,
    output logic                stall
);

    logic supported;
    logic is_imm;
    logic slot_found;
    logic issue;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // decode
    always_comb begin
        supported = 1'b1;
        is_imm    = 1'b0;
        op        = op_add;
        if (instr[6:0] == opcode_op_imm && instr[14:12] == 3'b000) begin
            is_imm = 1'b1; // addi
        end else if (instr[6:0] == opcode_op) begin
            case ({instr[31:25], instr[14:12]})
                {7'b0000000, 3'b000}: op = op_add;
                {7'b0100000, 3'b000}: op = op_sub;
                {7'b0000000, 3'b111}: op = op_and;
                {7'b0000000, 3'b100}: op = op_xor;
                {7'b0000001, 3'b000}: op = op_mul;
                default:              supported = 1'b0;
            endcase
        end else begin
            supported = 1'b0;
        end
    end

    // lowest free slot wins
    always_comb begin
        slot_found = 1'b0;
        rs_slot    = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!rs_busy[i]) begin
                slot_found = 1'b1;
                rs_slot    = rs_idx_t'(i);
            end
        end
    end

    // zero free tag also means no rob slot
    assign stall = !slot_found || rob_full || rob_tag_free == '0;

    assign issue     = issue_req && supported && !stall;
    assign rs_load   = issue;
    assign rob_alloc = issue;
    assign tag_write = issue && rd != '0; // x0 never renamed

    // operand j: cdb, then rob, then regfile, else wait on tag
    always_comb begin
        q_j = reg_tag_j;
        v_j = '0;
        if (reg_tag_j != '0 && cdb_valid && cdb_tag == reg_tag_j) begin
            q_j = '0;
            v_j = cdb_value;
        end else if (reg_tag_j != '0 && rob_ready_j) begin
            q_j = '0;
            v_j = rob_val_j;
        end else if (reg_tag_j == '0) begin
            v_j = reg_val_j;
        end
    end

    // operand k, immediate for addi
    always_comb begin
        q_k = reg_tag_k;
        v_k = '0;
        if (is_imm) begin
            q_k = '0;
            v_k = {{20{instr[31]}}, instr[31:20]};
        end else if (reg_tag_k != '0 && cdb_valid && cdb_tag == reg_tag_k) begin
            q_k = '0;
            v_k = cdb_value;
        end else if (reg_tag_k != '0 && rob_ready_k) begin
            q_k = '0;
            v_k = rob_val_k;
        end else if (reg_tag_k == '0) begin
            v_k = reg_val_k;
        end
    end

endmodule

`default_nettype wire

// File: testbench/ooo_checker.sv
// ##################################################
// ooo core checker
// compares commits and host register reads in order
// ##################################################

`timescale 1ns/100ps
`default_nettype none

module ooo_checker
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     wb_cyc,
    input  logic     wb_we,
    input  logic     wb_ack,
    input  word_t    wb_dat_r,
    input  logic     commit_valid,
    input  reg_idx_t commit_rd,
    input  word_t    commit_value,
    input  logic     exp_push,
    input  reg_idx_t exp_rd,
    input  word_t    exp_value,
    input  logic     rd_push,
    input  reg_idx_t rd_adr,
    input  word_t    rd_value,
    output int       pending,
    output int       n_checks,
    output int       n_errors
);

    reg_idx_t cm_rd_q  [$];
    word_t    cm_val_q [$];
    reg_idx_t rd_adr_q [$];
    word_t    rd_val_q [$];

    logic seen_req;
    logic idle_bad;
    int   n_commits;

    task automatic report_value(input string name, input word_t expected, input word_t actual);
        $display("ERROR @ %0t: %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
        n_errors++;
    endtask

    always @(posedge clk) begin
        logic ok;
        if (reset) begin
            cm_rd_q.delete();
            cm_val_q.delete();
            rd_adr_q.delete();
            rd_val_q.delete();
            seen_req  = 1'b0;
            idle_bad  = 1'b0;
            n_commits = 0;
            n_checks  = 0;
            n_errors  = 0;
        end else begin
            // outputs must stay quiet until the host starts
            if (!seen_req) begin
                if (wb_cyc) begin
                    seen_req = 1'b1;
                    n_checks++;
                    $display("idle after reset: %s", idle_bad ? "failed" : "ok");
                end else begin
                    if (commit_valid) begin
                        report_value("commit_valid", '0, {31'b0, commit_valid});
                        idle_bad = 1'b1;
                    end
                    if (wb_ack) begin
                        report_value("wb_ack", '0, {31'b0, wb_ack});
                        idle_bad = 1'b1;
                    end
                end
            end

            if (commit_valid) begin
                n_commits++;
                if (cm_rd_q.size() == 0) begin
                    $display("unexpected commit to x%0d at %0t with nothing outstanding",
                             commit_rd, $time);
                    n_errors++;
                end else begin
                    ok = 1'b1;
                    if (commit_rd !== cm_rd_q[0]) begin
                        report_value("commit_rd", {27'b0, cm_rd_q[0]}, {27'b0, commit_rd});
                        ok = 1'b0;
                    end
                    if (commit_value !== cm_val_q[0]) begin
                        report_value("commit_value", cm_val_q[0], commit_value);
                        ok = 1'b0;
                    end
                    n_checks++;
                    $display("commit %0d: x%0d = 0x%08h %s", n_commits, commit_rd,
                             commit_value, ok ? "ok" : "failed");
                    cm_rd_q.delete(0);
                    cm_val_q.delete(0);
                end
            end

            // we is held through the ack, so low here means a read
            if (wb_ack && !wb_we) begin
                if (rd_adr_q.size() == 0) begin
                    $display("read ack at %0t with no read outstanding", $time);
                    n_errors++;
                end else begin
                    ok = wb_dat_r === rd_val_q[0];
                    if (!ok)
                        report_value("wb_dat_r", rd_val_q[0], wb_dat_r);
                    n_checks++;
                    $display("read x%0d: 0x%08h %s", rd_adr_q[0], wb_dat_r,
                             ok ? "ok" : "failed");
                    rd_adr_q.delete(0);
                    rd_val_q.delete(0);
                end
            end

            if (exp_push) begin
                cm_rd_q.push_back(exp_rd);
                cm_val_q.push_back(exp_value);
            end
            if (rd_push) begin
                rd_adr_q.push_back(rd_adr);
                rd_val_q.push_back(rd_value);
            end
        end
        pending = cm_rd_q.size();
    end

endmodule

`default_nettype wire

// File: testbench/tb_ooo_core.sv
// ##################################################
// ooo core testbench
// issues an instruction table over wishbone,
// then reads back architectural registers
// ##################################################

`timescale 1ns/100ps
`default_nettype none

module tb_ooo_core
    import ooo_pkg::*;
();

    localparam int max_rows       = 24;
    localparam int n_reads        = 8;
    localparam int timeout_cycles = 200;

    logic     clk = 1'b0;
    logic     reset;
    logic     wb_cyc, wb_stb, wb_we, wb_ack;
    reg_idx_t wb_adr;
    word_t    wb_dat_w, wb_dat_r;
    logic     commit_valid;
    reg_idx_t commit_rd;
    word_t    commit_value;

    logic     exp_push, rd_push;
    reg_idx_t exp_rd, rd_adr;
    word_t    exp_value, rd_value;
    int       pending, n_checks, n_errors;
    logic     hung;

    word_t    prog_word   [max_rows];
    logic     prog_commit [max_rows];
    reg_idx_t prog_rd     [max_rows];
    word_t    prog_value  [max_rows];
    int       n_rows;
    int       n_commit_rows;
    reg_idx_t chk_adr   [n_reads];
    word_t    chk_value [n_reads];

    always #10 clk = ~clk;

    ooo_core dut0 (
        .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
    );

    ooo_checker check0 (
        .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_we(wb_we), .wb_ack(wb_ack),
        .wb_dat_r(wb_dat_r), .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_value(commit_value), .exp_push(exp_push), .exp_rd(exp_rd),
        .exp_value(exp_value), .rd_push(rd_push), .rd_adr(rd_adr), .rd_value(rd_value),
        .pending(pending), .n_checks(n_checks), .n_errors(n_errors)
    );

    function automatic word_t enc_r(input logic [6:0] funct7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] funct3,
                                    input reg_idx_t rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_addi(input logic [11:0] imm, input reg_idx_t rs1,
                                       input reg_idx_t rd);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    task automatic add_row(input word_t word, input logic commits, input reg_idx_t rd,
                           input word_t value);
        prog_word[n_rows]   = word;
        prog_commit[n_rows] = commits;
        prog_rd[n_rows]     = rd;
        prog_value[n_rows]  = value;
        n_rows++;
        if (commits)
            n_commit_rows++;
    endtask

    task automatic load_tables();
        // independent ops
        add_row(enc_addi(12'd5, 5'd0, 5'd1), 1'b1, 5'd1, 32'h0000_0005);
        add_row(enc_addi(12'd12, 5'd0, 5'd2), 1'b1, 5'd2, 32'h0000_000c);
        add_row(enc_addi(12'hffd, 5'd0, 5'd3), 1'b1, 5'd3, 32'hffff_fffd); // -3
        add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, 32'h0000_0011);
        add_row(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd5), 1'b1, 5'd5, 32'hffff_fff9);
        add_row(enc_r(7'h00, 5'd3, 5'd2, 3'b111, 5'd6), 1'b1, 5'd6, 32'h0000_000c);
        add_row(enc_r(7'h00, 5'd3, 5'd2, 3'b100, 5'd7), 1'b1, 5'd7, 32'hffff_fff1);
        add_row(enc_r(7'h01, 5'd2, 5'd3, 3'b000, 5'd8), 1'b1, 5'd8, 32'hffff_ffdc);
        // dependent chain, x10 written twice
        add_row(enc_r(7'h00, 5'd4, 5'd8, 3'b000, 5'd9), 1'b1, 5'd9, 32'hffff_ffed);
        add_row(enc_r(7'h20, 5'd1, 5'd9, 3'b000, 5'd10), 1'b1, 5'd10, 32'hffff_ffe8);
        add_row(enc_addi(12'd100, 5'd10, 5'd10), 1'b1, 5'd10, 32'h0000_004c);
        // burst hanging off one mul
        add_row(enc_r(7'h01, 5'd2, 5'd2, 3'b000, 5'd11), 1'b1, 5'd11, 32'h0000_0090);
        add_row(enc_r(7'h00, 5'd1, 5'd11, 3'b000, 5'd12), 1'b1, 5'd12, 32'h0000_0095);
        add_row(enc_r(7'h20, 5'd2, 5'd11, 3'b000, 5'd13), 1'b1, 5'd13, 32'h0000_0084);
        add_row(enc_r(7'h00, 5'd3, 5'd11, 3'b100, 5'd14), 1'b1, 5'd14, 32'hffff_ff6d);
        add_row(enc_r(7'h00, 5'd2, 5'd11, 3'b111, 5'd15), 1'b1, 5'd15, 32'h0000_0000);
        // x0 target commits, jal and div are dropped
        add_row(enc_addi(12'd33, 5'd1, 5'd0), 1'b1, 5'd0, 32'h0000_0026);
        add_row(32'h0000_006f, 1'b0, 5'd0, 32'h0);
        add_row(enc_r(7'h01, 5'd2, 5'd1, 3'b100, 5'd19), 1'b0, 5'd0, 32'h0);
        add_row(enc_addi(12'd7, 5'd0, 5'd17), 1'b1, 5'd17, 32'h0000_0007);
        add_row(enc_addi(12'd9, 5'd0, 5'd17), 1'b1, 5'd17, 32'h0000_0009);
        add_row(enc_r(7'h00, 5'd15, 5'd17, 3'b000, 5'd18), 1'b1, 5'd18, 32'h0000_0009);

        chk_adr[0]   = 5'd0;
        chk_value[0] = 32'h0000_0000;
        chk_adr[1]   = 5'd4;
        chk_value[1] = 32'h0000_0011;
        chk_adr[2]   = 5'd8;
        chk_value[2] = 32'hffff_ffdc;
        chk_adr[3]   = 5'd10;
        chk_value[3] = 32'h0000_004c;
        chk_adr[4]   = 5'd14;
        chk_value[4] = 32'hffff_ff6d;
        chk_adr[5]   = 5'd17;
        chk_value[5] = 32'h0000_0009;
        chk_adr[6]   = 5'd18;
        chk_value[6] = 32'h0000_0009;
        chk_adr[7]   = 5'd19;
        chk_value[7] = 32'h0000_0000; // never written
    endtask

    task automatic wait_ack(input string what);
        int waited;
        waited = 0;
        while (!wb_ack && waited < timeout_cycles) begin
            @(negedge clk);
            exp_push = 1'b0;
            rd_push  = 1'b0;
            waited++;
        end
        if (!wb_ack) begin
            hung = 1'b1;
            $display("timeout: no ack for %s within %0d cycles", what, timeout_cycles);
        end
        wb_cyc = 1'b0; // we stays put so the checker can tell reads apart
        wb_stb = 1'b0;
    endtask

    task automatic wb_write(input word_t word, input logic commits, input reg_idx_t rd,
                            input word_t value);
        @(negedge clk);
        wb_cyc    = 1'b1;
        wb_stb    = 1'b1;
        wb_we     = 1'b1;
        wb_dat_w  = word;
        exp_push  = commits;
        exp_rd    = rd;
        exp_value = value;
        wait_ack("instruction write");
    endtask

    task automatic wb_read(input reg_idx_t adr, input word_t value);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b0;
        wb_adr   = adr;
        rd_push  = 1'b1;
        rd_adr   = adr;
        rd_value = value;
        wait_ack("register read");
    endtask

    initial begin
        int waited;
        int checks_wanted;
        reset     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        exp_push  = 1'b0;
        exp_rd    = '0;
        exp_value = '0;
        rd_push   = 1'b0;
        rd_adr    = '0;
        rd_value  = '0;
        hung      = 1'b0;
        n_rows        = 0;
        n_commit_rows = 0;
        load_tables();

        repeat (5) @(negedge clk);
        reset = 1'b0;
        repeat (6) @(negedge clk); // quiet window watched by the checker

        for (int i = 0; i < n_rows && !hung; i++)
            wb_write(prog_word[i], prog_commit[i], prog_rd[i], prog_value[i]);

        // all commits must land before the register reads
        waited = 0;
        while (!hung && pending != 0 && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!hung && pending != 0) begin
            hung = 1'b1;
            $display("timeout: %0d commits never arrived", pending);
        end

        for (int i = 0; i < n_reads && !hung; i++)
            wb_read(chk_adr[i], chk_value[i]);
        @(negedge clk);

        checks_wanted = 1 + n_commit_rows + n_reads;
        if (!hung && n_checks != checks_wanted)
            $display("only %0d of %0d checks ran", n_checks, checks_wanted);
        $display("summary: %0d checks, %0d errors, %0d timeouts", n_checks, n_errors, hung);
        if (hung || n_errors != 0 || n_checks != checks_wanted)
            $display("STATUS: FAIL");
        else
            $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
